//--- fsmc_nor_sram.f
+incdir+hw
hw/fsmc_reg_pkg.sv
hw/fsmc_state_pkg.sv
hw/fsmc_bank_cfg_sel.sv
hw/fsmc_phase_timer.sv
hw/fsmc_access_fsm.sv
hw/fsmc_pin_drive.sv
hw/fsmc_nor_sram.sv
tests/fsmc_nor_sram_props.sv
tests/fsmc_nor_sram_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= fsmc_nor_sram_tb
FILELIST  ?= fsmc_nor_sram.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tests/fsmc_nor_sram_tb.sv
/*
  Random mode 1 / mode A accesses on bank 1, seed 26.
  Each access is checked cycle by cycle against a reference model.
  Request inputs are held stable until hreadyout returns high.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_nor_sram_tb;

  localparam int NUM_TESTS = 42;
  localparam int TIMEOUT   = 1000;

  logic                      hclk, hresetn, ahb_access, buf_we, tx_byte, tx_word;
  logic [`FSMC_SUBBANKS-1:0] bank1_region_sel;
  logic [`FSMC_ADDR_W-1:0]   buf_adr;
  logic [`FSMC_HWDATA_W-1:0] hwdata_r;
  logic [31:0]               bcr [4];
  logic [31:0]               btr [4];
  logic [31:0]               bwtr [4];
  logic                      hreadyout, word_1sthalf, fsmc_noe, fsmc_nwe;
  logic [`FSMC_ADDR_W-1:0]   fsmc_a;
  logic [`FSMC_DATA_W-1:0]   fsmc_do, fsmc_doen;
  logic [`FSMC_SUBBANKS-1:0] fsmc_ne;
  logic [1:0]                fsmc_nbl;
  int                        errors, failed_tests;
  logic                      timed_out;

  fsmc_nor_sram dut_i (
    .hclk(hclk), .hresetn(hresetn), .ahb_access(ahb_access), .buf_we(buf_we),
    .tx_byte(tx_byte), .tx_word(tx_word), .bank1_region_sel(bank1_region_sel),
    .buf_adr(buf_adr), .hwdata_r(hwdata_r),
    .bcr1(bcr[0]), .bcr2(bcr[1]), .bcr3(bcr[2]), .bcr4(bcr[3]),
    .btr1(btr[0]), .btr2(btr[1]), .btr3(btr[2]), .btr4(btr[3]),
    .bwtr1(bwtr[0]), .bwtr2(bwtr[1]), .bwtr3(bwtr[2]), .bwtr4(bwtr[3]),
    .hreadyout(hreadyout), .word_1sthalf(word_1sthalf), .fsmc_a(fsmc_a),
    .fsmc_do(fsmc_do), .fsmc_doen(fsmc_doen), .fsmc_ne(fsmc_ne),
    .fsmc_noe(fsmc_noe), .fsmc_nwe(fsmc_nwe), .fsmc_nbl(fsmc_nbl)
  );

  bind fsmc_nor_sram fsmc_nor_sram_props props_i (
    .hclk(hclk), .hresetn(hresetn), .hreadyout(hreadyout),
    .fsmc_ne(fsmc_ne), .fsmc_noe(fsmc_noe), .fsmc_nwe(fsmc_nwe)
  );

  initial begin
    hclk = 1'b0;
    forever #2 hclk = ~hclk; // 4 ns
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  task automatic check_reset_state();
    @(negedge hclk);
    if (!(hreadyout && fsmc_ne == 4'hf && fsmc_noe && fsmc_nwe && !word_1sthalf &&
          fsmc_nbl == 2'b11 && fsmc_doen == 16'h0 && fsmc_a == 26'h0)) begin
      $display("CHECK FAILED at %0t: pins not idle after reset", $time);
      errors++;
    end
    if (errors != 0)
      failed_tests++;
    $display("test reset: %s", (errors == 0) ? "ok" : "failed");
  endtask

  task automatic run_access(input int t);
    int          sel_i, size, bad, s_cyc, d_cyc, per_half, total, cyc, j, err0;
    logic        wr, ext, ok, second, setup, data;
    logic [31:0] tr;
    logic [66:0] exp_v, got_v;
    err0  = errors;
    sel_i = int'($urandom_range(0, 3));
    size  = t % 3;                      // 0 byte, 1 halfword, 2 word
    wr    = ((t / 3) % 2) == 1;
    ext   = 1'($urandom_range(0, 1));
    bad   = (t % 7 == 6) ? int'($urandom_range(1, 2)) : 0; // 1 disabled, 2 muxen
    ok    = (bad == 0);
    @(posedge hclk);
    #1;
    for (int k = 0; k < 4; k++) begin
      bcr[k]  = $urandom;
      btr[k]  = $urandom;
      bwtr[k] = $urandom;
    end
    bcr[sel_i]            = 32'h0;
    bcr[sel_i][0]         = (bad != 1);
    bcr[sel_i][1]         = (bad == 2);
    bcr[sel_i][14]        = ext;
    btr[sel_i]            = 32'h0;
    btr[sel_i][3:0]       = 4'($urandom_range(0, 4));
    btr[sel_i][15:8]      = 8'($urandom_range(0, 6));
    btr[sel_i][29:28]     = wr ? 2'b01 : 2'b00; // Mode A only in the applicable word
    bwtr[sel_i]           = 32'h0;
    bwtr[sel_i][3:0]      = 4'($urandom_range(0, 4));
    bwtr[sel_i][15:8]     = 8'($urandom_range(0, 6));
    bwtr[sel_i][29:28]    = wr ? 2'b00 : 2'b01;
    bank1_region_sel = 4'(1 << sel_i);
    buf_adr          = 26'($urandom);
    hwdata_r         = $urandom;
    buf_we           = wr;
    tx_byte          = (size == 0);
    tx_word          = (size == 2);
    ahb_access       = 1'b1;
    @(posedge hclk);
    #1 ahb_access = 1'b0;

    // Reference timing
    tr       = (ext && wr) ? bwtr[sel_i] : btr[sel_i];
    s_cyc    = (tr[3:0] == 4'h0) ? 1 : int'(tr[3:0]);
    d_cyc    = (tr[15:8] == 8'h0) ? 1 : int'(tr[15:8]);
    per_half = s_cyc + d_cyc + (wr ? 1 : 0);
    total    = (size == 2) ? 2 * per_half : per_half;

    for (cyc = 0; cyc < TIMEOUT; cyc++) begin
      @(negedge hclk);
      if (hreadyout)
        break;
      if (cyc < total) begin
        second = (cyc >= per_half);
        j      = cyc % per_half;
        setup  = (j < s_cyc);
        data   = !setup && (j < s_cyc + d_cyc);
        exp_v  = {(size == 0) ? buf_adr : (buf_adr >> 1) + (second ? 26'd1 : 26'd0),
                  (wr && !setup) ? (second ? hwdata_r[31:16] : hwdata_r[15:0]) : 16'h0,
                  (wr && !setup) ? 16'hffff : 16'h0,
                  ok ? ~bank1_region_sel : 4'hf,
                  !(ok && !wr && (ext ? data : 1'b1)),
                  !(ok && wr && data),
                  (size == 0) ? {~buf_adr[0], buf_adr[0]} : 2'b00,
                  (size == 2) && !wr && !second && data};
        got_v  = {fsmc_a, fsmc_do, fsmc_doen, fsmc_ne, fsmc_noe, fsmc_nwe,
                  fsmc_nbl, word_1sthalf};
        if (got_v !== exp_v) begin
          $display("CHECK FAILED at %0t: test %0d cycle %0d pins %h expected %h",
                   $time, t, cyc, got_v, exp_v);
          errors++;
        end
      end
    end
    if (cyc == TIMEOUT) begin
      $display("Timeout in test %0d: hreadyout stayed low for %0d cycles", t, TIMEOUT);
      timed_out = 1'b1;
    end else if (cyc != total) begin
      $display("CHECK FAILED at %0t: test %0d busy for %0d cycles, expected %0d",
               $time, t, cyc, total);
      errors++;
    end
    if (errors != err0 || timed_out)
      failed_tests++;
    $display("test %0d: ne%0d size %0d %s ext %0d ok %0d busy %0d: %s", t, sel_i + 1,
             size, wr ? "write" : "read", ext, ok, total,
             (errors == err0 && !timed_out) ? "ok" : "failed");
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    void'($urandom(26));
    errors = 0;
    failed_tests = 0;
    timed_out = 1'b0;
    hresetn = 1'b0;
    ahb_access = 1'b0;
    buf_we = 1'b0;
    tx_byte = 1'b0;
    tx_word = 1'b0;
    bank1_region_sel = 4'h0;
    buf_adr = '0;
    hwdata_r = '0;
    for (int k = 0; k < 4; k++) begin
      bcr[k]  = 32'h0;
      btr[k]  = 32'h0;
      bwtr[k] = 32'h0;
    end
    repeat (16) @(posedge hclk);
    #1 hresetn = 1'b1;
    check_reset_state();
    for (int t = 0; t < NUM_TESTS && !timed_out; t++)
      run_access(t);
    $display("Summary: %0d tests, %0d failed, %0d check errors", NUM_TESTS + 1,
             failed_tests, errors);
    if (errors == 0 && !timed_out)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- tests/fsmc_nor_sram_props.sv
/*
  Pin protocol assertions, bound into the controller top level.
  Checked only outside reset.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_nor_sram_props (
  input logic                      hclk,
  input logic                      hresetn,
  input logic                      hreadyout,
  input logic [`FSMC_SUBBANKS-1:0] fsmc_ne,
  input logic                      fsmc_noe,
  input logic                      fsmc_nwe
);

  // ----------------------------------------
  // Strobe and enable exclusivity
  // ----------------------------------------
  a_strobe_excl: assert property (@(posedge hclk) disable iff (!hresetn)
    !(!fsmc_noe && !fsmc_nwe))
    else $error("noe and nwe are both low");

  a_ne_onehot0: assert property (@(posedge hclk) disable iff (!hresetn)
    $onehot0(~fsmc_ne))
    else $error("more than one ne line is low");

  // Idle bus keeps the memory quiet
  a_idle_quiet: assert property (@(posedge hclk) disable iff (!hresetn)
    hreadyout |-> (fsmc_noe && fsmc_nwe && (&fsmc_ne)))
    else $error("strobe or enable active while ready");

endmodule

//--- hw/fsmc_nor_sram.sv
/*
  Bank 1 asynchronous NOR/SRAM controller, mode 1 and mode A only.
  The request inputs (select, address, size, direction, write data)
  must stay stable from ahb_access until hreadyout returns high.
  No wait input, no memory clock, no multiplexed address/data.
  A word access runs as two halfwords at consecutive addresses.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_nor_sram (
  input  logic                      hclk,
  input  logic                      hresetn,
  input  logic                      ahb_access,
  input  logic                      buf_we,
  input  logic                      tx_byte,
  input  logic                      tx_word,
  input  logic [`FSMC_SUBBANKS-1:0] bank1_region_sel,
  input  logic [`FSMC_ADDR_W-1:0]   buf_adr,
  input  logic [`FSMC_HWDATA_W-1:0] hwdata_r,
  input  logic [31:0]               bcr1, bcr2, bcr3, bcr4,
  input  logic [31:0]               btr1, btr2, btr3, btr4,
  input  logic [31:0]               bwtr1, bwtr2, bwtr3, bwtr4,
  output logic                      hreadyout,
  output logic                      word_1sthalf,
  output logic [`FSMC_ADDR_W-1:0]   fsmc_a,
  output logic [`FSMC_DATA_W-1:0]   fsmc_do,
  output logic [`FSMC_DATA_W-1:0]   fsmc_doen,
  output logic [`FSMC_SUBBANKS-1:0] fsmc_ne,
  output logic                      fsmc_noe,
  output logic                      fsmc_nwe,
  output logic [1:0]                fsmc_nbl
);

  logic [`FSMC_SET_W-1:0]   addset_lim;
  logic [`FSMC_DST_W-1:0]   datast_lim;
  logic                     mode_ok, oe_data_only, phase_done;
  logic [`FSMC_STATE_W-1:0] state;

  fsmc_bank_cfg_sel cfg_i (
    .region_sel(bank1_region_sel), .write(buf_we),
    .bcr1(bcr1), .bcr2(bcr2), .bcr3(bcr3), .bcr4(bcr4),
    .btr1(btr1), .btr2(btr2), .btr3(btr3), .btr4(btr4),
    .bwtr1(bwtr1), .bwtr2(bwtr2), .bwtr3(bwtr3), .bwtr4(bwtr4),
    .addset_lim(addset_lim), .datast_lim(datast_lim),
    .mode_ok(mode_ok), .oe_data_only(oe_data_only)
  );

  fsmc_phase_timer timer_i (
    .hclk(hclk), .hresetn(hresetn), .state(state),
    .addset_lim(addset_lim), .datast_lim(datast_lim), .phase_done(phase_done)
  );

  fsmc_access_fsm fsm_i (
    .hclk(hclk), .hresetn(hresetn), .ahb_access(ahb_access), .write(buf_we),
    .tx_word(tx_word), .phase_done(phase_done), .state(state),
    .hreadyout(hreadyout), .word_1sthalf(word_1sthalf)
  );

  fsmc_pin_drive pins_i (
    .state(state), .region_sel(bank1_region_sel), .mode_ok(mode_ok),
    .oe_data_only(oe_data_only), .write(buf_we), .tx_byte(tx_byte),
    .buf_adr(buf_adr), .hwdata_r(hwdata_r), .fsmc_a(fsmc_a), .fsmc_do(fsmc_do),
    .fsmc_doen(fsmc_doen), .fsmc_ne(fsmc_ne), .fsmc_noe(fsmc_noe),
    .fsmc_nwe(fsmc_nwe), .fsmc_nbl(fsmc_nbl)
  );

endmodule

//--- hw/fsmc_pin_drive.sv
/*
  Memory pin decode, purely combinational from the FSM state.
  Strobes and chip enables stay inactive when mode_ok is low,
  while address, data and byte lanes still follow the state.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_pin_drive (
  input  logic [`FSMC_STATE_W-1:0]  state,
  input  logic [`FSMC_SUBBANKS-1:0] region_sel,
  input  logic                      mode_ok,
  input  logic                      oe_data_only,
  input  logic                      write,
  input  logic                      tx_byte,
  input  logic [`FSMC_ADDR_W-1:0]   buf_adr,
  input  logic [`FSMC_HWDATA_W-1:0] hwdata_r,
  output logic [`FSMC_ADDR_W-1:0]   fsmc_a,
  output logic [`FSMC_DATA_W-1:0]   fsmc_do,
  output logic [`FSMC_DATA_W-1:0]   fsmc_doen,
  output logic [`FSMC_SUBBANKS-1:0] fsmc_ne,
  output logic                      fsmc_noe,
  output logic                      fsmc_nwe,
  output logic [1:0]                fsmc_nbl
);

  logic                    busy;
  logic                    second;
  logic [`FSMC_ADDR_W-1:0] hw_adr;

  assign busy   = (state != fsmc_state_pkg::st_idle);
  assign second = fsmc_state_pkg::is_second_half(state);
  assign hw_adr = buf_adr >> 1; // Halfword address

  // ----------------------------------------
  // Address and data
  // ----------------------------------------
  always_comb begin
    if (!busy)
      fsmc_a = '0;
    else if (tx_byte)
      fsmc_a = buf_adr;
    else if (second)
      fsmc_a = hw_adr + 26'd1;
    else
      fsmc_a = hw_adr;
  end

  always_comb begin
    fsmc_do = '0;
    if (fsmc_state_pkg::is_write_data(state))
      fsmc_do = second ? hwdata_r[31:16] : hwdata_r[15:0];
  end

  assign fsmc_doen = fsmc_state_pkg::is_write_data(state) ? '1 : '0;

  // ----------------------------------------
  // Strobes, enables, byte lanes
  // ----------------------------------------
  assign fsmc_nwe = !(mode_ok && ((state == fsmc_state_pkg::st_data1_w) ||
                                  (state == fsmc_state_pkg::st_data2_w)));

  // Mode A drops OE during setup
  assign fsmc_noe = !(mode_ok && !write &&
                      (oe_data_only ? fsmc_state_pkg::is_data(state) : busy));

  assign fsmc_ne = ~(region_sel & {`FSMC_SUBBANKS{busy && mode_ok}});

  assign fsmc_nbl = !busy  ? 2'b11 :
                    tx_byte ? {~buf_adr[0], buf_adr[0]} : 2'b00;

endmodule

//--- hw/fsmc_access_fsm.sv
/*
  Access FSM for one halfword, or two halves for a word transfer.
  A new access is taken only in idle; ahb_access is ignored while busy.
  Write, tx_word and the select must not change during an access.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_access_fsm (
  input  logic                     hclk,
  input  logic                     hresetn,
  input  logic                     ahb_access,
  input  logic                     write,
  input  logic                     tx_word,
  input  logic                     phase_done,
  output logic [`FSMC_STATE_W-1:0] state,
  output logic                     hreadyout,
  output logic                     word_1sthalf
);

  logic [`FSMC_STATE_W-1:0] state_nxt;

  // ----------------------------------------
  // Next state
  // ----------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      fsmc_state_pkg::st_idle:
        if (ahb_access)
          state_nxt = fsmc_state_pkg::st_set1;
      fsmc_state_pkg::st_set1:
        if (phase_done)
          state_nxt = write ? fsmc_state_pkg::st_data1_w : fsmc_state_pkg::st_data1_r;
      fsmc_state_pkg::st_data1_w:
        if (phase_done)
          state_nxt = fsmc_state_pkg::st_data1_wf;
      fsmc_state_pkg::st_data1_wf:
        state_nxt = tx_word ? fsmc_state_pkg::st_set2 : fsmc_state_pkg::st_idle;
      fsmc_state_pkg::st_data1_r:
        if (phase_done)
          state_nxt = tx_word ? fsmc_state_pkg::st_set2 : fsmc_state_pkg::st_idle;
      fsmc_state_pkg::st_set2:
        if (phase_done)
          state_nxt = write ? fsmc_state_pkg::st_data2_w : fsmc_state_pkg::st_data2_r;
      fsmc_state_pkg::st_data2_w:
        if (phase_done)
          state_nxt = fsmc_state_pkg::st_data2_wf;
      fsmc_state_pkg::st_data2_wf:
        state_nxt = fsmc_state_pkg::st_idle;
      fsmc_state_pkg::st_data2_r:
        if (phase_done)
          state_nxt = fsmc_state_pkg::st_idle;
      default:
        state_nxt = fsmc_state_pkg::st_idle;
    endcase
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn)
      state <= fsmc_state_pkg::st_idle;
    else
      state <= state_nxt;
  end

  // ----------------------------------------
  // Bus side flags
  // ----------------------------------------
  assign hreadyout = (state == fsmc_state_pkg::st_idle);

  // First read half is valid on the memory bus
  assign word_1sthalf = tx_word && (state == fsmc_state_pkg::st_data1_r);

endmodule

//--- hw/fsmc_phase_timer.sv
/*
  Phase cycle counter. A zero timing field is run as one cycle.
  Counting restarts after every phase end, so each state starts at 1.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_phase_timer (
  input  logic                     hclk,
  input  logic                     hresetn,
  input  logic [`FSMC_STATE_W-1:0] state,
  input  logic [`FSMC_SET_W-1:0]   addset_lim,
  input  logic [`FSMC_DST_W-1:0]   datast_lim,
  output logic                     phase_done
);

  logic [`FSMC_DST_W-1:0] cnt;
  logic [`FSMC_DST_W-1:0] set_eff;
  logic [`FSMC_DST_W-1:0] dat_eff;
  logic                   wr_fin;

  assign set_eff = (addset_lim == '0) ? 8'd1 : {4'd0, addset_lim};
  assign dat_eff = (datast_lim == '0) ? 8'd1 : datast_lim;

  assign wr_fin = (state == fsmc_state_pkg::st_data1_wf) ||
                  (state == fsmc_state_pkg::st_data2_wf);

  always_comb begin
    if (wr_fin)
      phase_done = 1'b1;                    // Single cycle
    else if (fsmc_state_pkg::is_setup(state))
      phase_done = (cnt == set_eff);
    else if (fsmc_state_pkg::is_data(state))
      phase_done = (cnt == dat_eff);
    else
      phase_done = 1'b0;
  end

  always_ff @(posedge hclk or negedge hresetn) begin
    if (!hresetn)
      cnt <= 8'd1;
    else if (state == fsmc_state_pkg::st_idle || phase_done)
      cnt <= 8'd1;
    else
      cnt <= cnt + 8'd1;
  end

endmodule

//--- hw/fsmc_bank_cfg_sel.sv
/*
  Picks the configuration of the selected sub-bank and decodes it.
  Only mode 1 and mode A on non-multiplexed memories are accepted;
  anything else, or a select that is not one-hot, clears mode_ok.
*/
`timescale 1ns/1ps
`include "fsmc_defs.svh"

module fsmc_bank_cfg_sel (
  input  logic [`FSMC_SUBBANKS-1:0] region_sel,
  input  logic                      write,
  input  logic [31:0]               bcr1,
  input  logic [31:0]               bcr2,
  input  logic [31:0]               bcr3,
  input  logic [31:0]               bcr4,
  input  logic [31:0]               btr1,
  input  logic [31:0]               btr2,
  input  logic [31:0]               btr3,
  input  logic [31:0]               btr4,
  input  logic [31:0]               bwtr1,
  input  logic [31:0]               bwtr2,
  input  logic [31:0]               bwtr3,
  input  logic [31:0]               bwtr4,
  output logic [`FSMC_SET_W-1:0]    addset_lim,
  output logic [`FSMC_DST_W-1:0]    datast_lim,
  output logic                      mode_ok,
  output logic                      oe_data_only
);

  logic [31:0] bcr, btr, bwtr, tr;
  logic        sel_ok;
  logic        extmod;
  logic        mode_a;

  // ----------------------------------------
  // Sub-bank mux
  // ----------------------------------------
  always_comb begin
    sel_ok = 1'b1;
    case (region_sel)
      4'b0001: begin bcr = bcr1; btr = btr1; bwtr = bwtr1; end
      4'b0010: begin bcr = bcr2; btr = btr2; bwtr = bwtr2; end
      4'b0100: begin bcr = bcr3; btr = btr3; bwtr = bwtr3; end
      4'b1000: begin bcr = bcr4; btr = btr4; bwtr = bwtr4; end
      default: begin
        bcr    = '0;
        btr    = '0;
        bwtr   = '0;
        sel_ok = 1'b0;
      end
    endcase
  end

  assign extmod = fsmc_reg_pkg::bcr_extmod(bcr);
  assign tr     = (extmod && write) ? bwtr : btr; // Write timing in extended mode

  assign addset_lim = fsmc_reg_pkg::tr_addset(tr);
  assign datast_lim = fsmc_reg_pkg::tr_datast(tr);

  assign mode_a = extmod && (fsmc_reg_pkg::tr_accmod(tr) == 2'b00);

  assign mode_ok = sel_ok && fsmc_reg_pkg::bcr_mbken(bcr) &&
                   !fsmc_reg_pkg::bcr_muxen(bcr) && !fsmc_reg_pkg::bcr_mtyp_hi(bcr) &&
                   (!extmod || mode_a);

  assign oe_data_only = mode_a;

endmodule

//--- hw/fsmc_state_pkg.sv
/*
  Access FSM state codes and state classification helpers.
*/
`include "fsmc_defs.svh"

package fsmc_state_pkg;

  localparam logic [`FSMC_STATE_W-1:0] st_idle     = 4'd0;
  localparam logic [`FSMC_STATE_W-1:0] st_set1     = 4'd1;
  localparam logic [`FSMC_STATE_W-1:0] st_data1_w  = 4'd2;
  localparam logic [`FSMC_STATE_W-1:0] st_data1_wf = 4'd3; // Write finish
  localparam logic [`FSMC_STATE_W-1:0] st_data1_r  = 4'd4;
  localparam logic [`FSMC_STATE_W-1:0] st_set2     = 4'd5;
  localparam logic [`FSMC_STATE_W-1:0] st_data2_w  = 4'd6;
  localparam logic [`FSMC_STATE_W-1:0] st_data2_wf = 4'd7;
  localparam logic [`FSMC_STATE_W-1:0] st_data2_r  = 4'd8;

  function automatic logic is_setup(input logic [`FSMC_STATE_W-1:0] s);
    return (s == st_set1) || (s == st_set2);
  endfunction

  // Write finish states are not counted as data phases
  function automatic logic is_data(input logic [`FSMC_STATE_W-1:0] s);
    return (s == st_data1_w) || (s == st_data1_r) ||
           (s == st_data2_w) || (s == st_data2_r);
  endfunction

  function automatic logic is_second_half(input logic [`FSMC_STATE_W-1:0] s);
    return (s == st_set2) || (s == st_data2_w) ||
           (s == st_data2_wf) || (s == st_data2_r);
  endfunction

  function automatic logic is_write_data(input logic [`FSMC_STATE_W-1:0] s);
    return (s == st_data1_w) || (s == st_data1_wf) ||
           (s == st_data2_w) || (s == st_data2_wf);
  endfunction

endpackage

//--- hw/fsmc_reg_pkg.sv
/*
  Field extraction for the bank control word (BCR) and the
  read and write timing words (BTR, BWTR).
  BTR and BWTR share the same layout for the fields taken here.
*/
`include "fsmc_defs.svh"

package fsmc_reg_pkg;

  // ----------------------------------------
  // BCR fields
  // ----------------------------------------
  function automatic logic bcr_mbken(input logic [31:0] bcr);
    return bcr[`FSMC_BCR_MBKEN];
  endfunction

  function automatic logic bcr_muxen(input logic [31:0] bcr);
    return bcr[`FSMC_BCR_MUXEN];
  endfunction

  // NOR flash type when set
  function automatic logic bcr_mtyp_hi(input logic [31:0] bcr);
    return bcr[`FSMC_BCR_MTYP_HI];
  endfunction

  function automatic logic bcr_extmod(input logic [31:0] bcr);
    return bcr[`FSMC_BCR_EXTMOD];
  endfunction

  // ----------------------------------------
  // Timing word fields
  // ----------------------------------------
  function automatic logic [`FSMC_SET_W-1:0] tr_addset(input logic [31:0] tr);
    return tr[`FSMC_TR_ADDSET_LSB +: `FSMC_SET_W];
  endfunction

  function automatic logic [`FSMC_DST_W-1:0] tr_datast(input logic [31:0] tr);
    return tr[`FSMC_TR_DATAST_LSB +: `FSMC_DST_W];
  endfunction

  // 00 selects mode A when extended mode is on
  function automatic logic [`FSMC_ACC_W-1:0] tr_accmod(input logic [31:0] tr);
    return tr[`FSMC_TR_ACCMOD_LSB +: `FSMC_ACC_W];
  endfunction

endpackage

//--- hw/fsmc_defs.svh
/*
  Bank 1 NOR/SRAM controller widths and register field positions.
  Field positions follow the bank control and timing word layout;
  only the fields used by mode 1 and mode A are listed.
*/
`ifndef FSMC_DEFS_SVH
`define FSMC_DEFS_SVH

// ----------------------------------------
// Bus and memory widths
// ----------------------------------------
`define FSMC_ADDR_W     26
`define FSMC_DATA_W     16
`define FSMC_HWDATA_W   32
`define FSMC_SUBBANKS   4
`define FSMC_STATE_W    4

// Timing field widths
`define FSMC_SET_W      4
`define FSMC_DST_W      8
`define FSMC_ACC_W      2

// ----------------------------------------
// BCR bit positions
// ----------------------------------------
`define FSMC_BCR_MBKEN    0
`define FSMC_BCR_MUXEN    1
`define FSMC_BCR_MTYP_HI  3
`define FSMC_BCR_EXTMOD   14

// BTR / BWTR field low bits
`define FSMC_TR_ADDSET_LSB  0
`define FSMC_TR_DATAST_LSB  8
`define FSMC_TR_ACCMOD_LSB  28

`endif
